/* hlc_pkg.sv */
// Shared definitions for the host-link packet controller
// Link word layout, return word layout, register map and status words
// Referenced by scoped name from every RTL file that needs it

package hlc_pkg;

    localparam logic [7:0] LINK_MAGIC = 8'h77;  // Bits 7:0 of every valid word

    // Inbound word type, reused as return tag
    typedef enum logic [1:0] {
        LT_TLP  = 2'd0,
        LT_CFG  = 2'd1,
        LT_LOOP = 2'd2,
        LT_CMD  = 2'd3
    } link_type_e;

    // Return mux source select
    typedef enum logic [1:0] {SRC_NONE, SRC_CFG, SRC_LOOP, SRC_RSP} ret_src_e;

    // Command engine push selection, in priority order
    typedef enum logic [1:0] {ACT_NONE, ACT_READ, ACT_SEND, ACT_IDLE} cmd_act_e;

    typedef struct packed {
        logic [15:0] value;     // Byte swapped
        logic [15:0] mask;      // Byte swapped
        logic [15:0] addr;      // Bit 15 selects RW space
        logic [1:0]  spare;
        logic        wr_flag;
        logic        rd_flag;
        logic [1:0]  ctx;       // Bit 0 is TLP last
        link_type_e  ltype;
        logic [7:0]  magic;
    } link_word_t;

    typedef struct packed {
        link_type_e  tag;
        logic [1:0]  ctx;
        logic [31:0] data;
    } ret_word_t;

    typedef struct packed {
        logic [1:0]  ctx;
        logic [31:0] data;      // Upper half of the link word
    } loop_word_t;

    typedef struct packed {
        logic        valid;
        logic        last;
        logic [31:0] data;
    } tlp_out_t;

    typedef struct packed {
        logic       valid;
        link_word_t word;
    } cfg_out_t;

    // ------------------------------------------------
    // Register map, byte offsets
    // ------------------------------------------------
    localparam logic [15:0] RO_MAGIC = 16'hab89;
    localparam logic [15:0] RW_MAGIC = 16'hefcd;
    localparam int RO_BITS = 256;
    localparam int RW_BITS = 96;

    localparam int RO_OFS_MAGIC      = 'h00;
    localparam int RO_OFS_BYTECOUNT  = 'h04;
    localparam int RO_OFS_VER_MAJOR  = 'h08;
    localparam int RO_OFS_VER_MINOR  = 'h09;
    localparam int RO_OFS_DEVICE_ID  = 'h0a;
    localparam int RO_OFS_UPTIME     = 'h10;    // 64 bits
    localparam int RO_OFS_INACT_BASE = 'h18;    // 64 bits

    localparam int RW_OFS_MAGIC       = 'h00;
    localparam int RW_OFS_CONTROL     = 'h02;
    localparam int RW_OFS_SEND_COUNT  = 'h04;   // Shares the bytecount word
    localparam int RW_OFS_INACT_TICKS = 'h08;   // 32 bits
    localparam int CTRL_INACT_EN      = 0;
    localparam int CTRL_SEND_EN       = 1;

    localparam logic [15:0] RW_CONTROL_RST = 16'h0000;  // Both timers off
    localparam logic [31:0] RW_TICKS_RST   = 32'h0000_0000;
    localparam logic [RW_BITS-1:0] RW_RESET =
        {RW_TICKS_RST, 32'(RW_BITS / 8), RW_CONTROL_RST, RW_MAGIC};

    // Unsolicited status words
    localparam logic [15:0] ADDR_SEND_COUNT = 16'hfffe;
    localparam logic [15:0] ADDR_INACTIVE   = 16'hffff;
    localparam logic [15:0] INACTIVE_DATA   = 16'hcede;

endpackage

/* hlc_sync_fifo.sv */
// First-word-fall-through synchronous FIFO
// Head entry sits on o_dout whenever o_valid is high; i_rd pops it
// Used for the loopback, command request and command response queues

`timescale 1ns/1ps

module hlc_sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_din,
    input  logic             i_rd,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_valid,
    output logic             o_almost_full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];      // No reset on storage
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             full;

    assign full          = (count == CW'(DEPTH));
    assign o_valid       = (count != '0);
    assign o_dout        = mem[rd_ptr];           // Fall through
    assign o_almost_full = (count >= CW'(DEPTH - 2));

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_rd) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(i_wr) - CW'(i_rd);   // Both at once holds level
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    // Producer must respect full, except when the head leaves this cycle
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        i_wr && full |-> i_rd);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        i_rd |-> o_valid);

endmodule

/* hlc_link_decode.sv */
// Inbound link word decoder, purely combinational
// Checks the magic byte and steers each valid word by its type
// Bad magic words are dropped with no strobe

`timescale 1ns/1ps

module hlc_link_decode (
    input  hlc_pkg::link_word_t i_link,
    input  logic                i_link_valid,
    output hlc_pkg::tlp_out_t   o_tlp,
    output hlc_pkg::cfg_out_t   o_cfg,
    output logic                o_loop_wr,
    output hlc_pkg::loop_word_t o_loop_din,
    output logic                o_cmd_wr,
    output hlc_pkg::link_word_t o_cmd_din
);

    logic hit;

    assign hit = i_link_valid && (i_link.magic == hlc_pkg::LINK_MAGIC);

    // TLP path carries upper 32 bits and the last flag
    assign o_tlp.valid = hit && (i_link.ltype == hlc_pkg::LT_TLP);
    assign o_tlp.last  = i_link.ctx[0];
    assign o_tlp.data  = {i_link.value, i_link.mask};

    // CFG gets the whole word
    assign o_cfg.valid = hit && (i_link.ltype == hlc_pkg::LT_CFG);
    assign o_cfg.word  = i_link;

    assign o_loop_wr       = hit && (i_link.ltype == hlc_pkg::LT_LOOP);
    assign o_loop_din.ctx  = i_link.ctx;                    // Echoed as return ctx
    assign o_loop_din.data = {i_link.value, i_link.mask};

    assign o_cmd_wr  = hit && (i_link.ltype == hlc_pkg::LT_CMD);
    assign o_cmd_din = i_link;

    // One destination per accepted word
    always_comb begin
        a_one_strobe: assert ($onehot0({o_tlp.valid, o_cfg.valid, o_loop_wr, o_cmd_wr}));
    end

endmodule

/* hlc_cmd_engine.sv */
// Command engine with the register file and the unsolicited status words
// Pops one request per cycle; the response push lands one cycle later
// Priority is read, then send count, then inactivity

`timescale 1ns/1ps

module hlc_cmd_engine #(
    parameter logic [7:0] DEVICE_ID     = 8'h00,
    parameter logic [7:0] VERSION_MAJOR = 8'h00,
    parameter logic [7:0] VERSION_MINOR = 8'h00
) (
    input  logic                clk,
    input  logic                rst,
    input  hlc_pkg::link_word_t i_req,
    input  logic                i_req_valid,
    output logic                o_req_rd,
    input  logic                i_ret_xfer,
    input  logic                i_ret_ready,
    input  logic                i_rsp_almost_full,
    output logic                o_rsp_wr,
    output logic [31:0]         o_rsp_din
);

    localparam int CTRL_BIT = hlc_pkg::RW_OFS_CONTROL * 8;
    localparam int CNT_BIT  = hlc_pkg::RW_OFS_SEND_COUNT * 8;
    localparam int TICK_BIT = hlc_pkg::RW_OFS_INACT_TICKS * 8;

    logic [hlc_pkg::RW_BITS-1:0]    rw;
    logic [hlc_pkg::RO_BITS-1:0]    ro;
    logic [hlc_pkg::RW_BITS+15:0]   rw_ext;         // Zero pad for top slices
    logic [hlc_pkg::RO_BITS+15:0]   ro_ext;
    logic [63:0]        uptime;
    logic [63:0]        inact_base;
    logic [17:0]        bit_addr;
    logic [15:0]        wr_value;
    logic [15:0]        wr_mask;
    logic [15:0]        rd_data;
    logic               rd_req;
    logic               wr_req;
    logic               send_en;
    logic               idle_hit;
    logic [15:0]        send_count;
    hlc_pkg::cmd_act_e  act;

    // ------------------------------------------------
    // Read-only image
    // ------------------------------------------------
    always_comb begin
        ro = '0;
        ro[hlc_pkg::RO_OFS_MAGIC*8 +: 16]      = hlc_pkg::RO_MAGIC;
        ro[hlc_pkg::RO_OFS_BYTECOUNT*8 +: 32]  = 32'(hlc_pkg::RO_BITS / 8);
        ro[hlc_pkg::RO_OFS_VER_MAJOR*8 +: 8]   = VERSION_MAJOR;
        ro[hlc_pkg::RO_OFS_VER_MINOR*8 +: 8]   = VERSION_MINOR;
        ro[hlc_pkg::RO_OFS_DEVICE_ID*8 +: 8]   = DEVICE_ID;
        ro[hlc_pkg::RO_OFS_UPTIME*8 +: 64]     = uptime;
        ro[hlc_pkg::RO_OFS_INACT_BASE*8 +: 64] = inact_base;
    end

    assign rw_ext = {16'h0000, rw};
    assign ro_ext = {16'h0000, ro};

    // Request fields, value and mask arrive byte swapped
    assign o_req_rd = i_req_valid;                  // Always take the head
    assign bit_addr = {i_req.addr[14:0], 3'b000};
    assign wr_value = {i_req.value[7:0], i_req.value[15:8]};
    assign wr_mask  = {i_req.mask[7:0], i_req.mask[15:8]};
    assign rd_req   = i_req_valid && i_req.rd_flag;
    assign wr_req   = i_req_valid && i_req.wr_flag && i_req.addr[15];   // RO writes ignored

    always_comb begin
        rd_data = 16'h0000;                         // Out of range reads as 0
        if (i_req.addr[15]) begin
            if (bit_addr < 18'(hlc_pkg::RW_BITS)) begin
                rd_data = rw_ext[bit_addr[6:0] +: 16];
            end
        end else if (bit_addr < 18'(hlc_pkg::RO_BITS)) begin
            rd_data = ro_ext[bit_addr[7:0] +: 16];
        end
    end

    // Status triggers
    assign send_count = rw[CNT_BIT +: 16];
    assign send_en    = rw[CTRL_BIT + hlc_pkg::CTRL_SEND_EN] && (send_count != 16'h0000);
    assign idle_hit   = rw[CTRL_BIT + hlc_pkg::CTRL_INACT_EN] &&
                        (uptime > inact_base + {32'h0, rw[TICK_BIT +: 32]});

    always_comb begin
        act = hlc_pkg::ACT_NONE;
        if (rd_req) begin
            act = hlc_pkg::ACT_READ;                // Reads always win
        end else if (!i_rsp_almost_full && !wr_req && send_en) begin
            act = hlc_pkg::ACT_SEND;
        end else if (!i_rsp_almost_full && !wr_req && idle_hit) begin
            act = hlc_pkg::ACT_IDLE;
        end
    end

    // ------------------------------------------------
    // Register file and timers
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rw         <= hlc_pkg::RW_RESET;
            uptime     <= '0;
            inact_base <= '0;
            o_rsp_wr   <= 1'b0;
        end else begin
            uptime   <= uptime + 64'd1;
            o_rsp_wr <= (act != hlc_pkg::ACT_NONE);
            if (act == hlc_pkg::ACT_SEND) begin
                rw[CNT_BIT +: 16] <= send_count - 16'd1;
            end
            if (act == hlc_pkg::ACT_IDLE) begin
                rw[CTRL_BIT + hlc_pkg::CTRL_INACT_EN] <= 1'b0;   // One shot
            end
            if (wr_req) begin
                for (int i = 0; i < 16; i++) begin
                    if (wr_mask[i] && (int'(bit_addr) + i < hlc_pkg::RW_BITS)) begin
                        rw[int'(bit_addr) + i] <= wr_value[i];
                    end
                end
            end
            // Link busy or stalled restarts the idle window
            if (i_ret_xfer || !i_ret_ready) begin
                inact_base <= uptime;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        case (act)
            hlc_pkg::ACT_READ: o_rsp_din <= {i_req.addr, rd_data[7:0], rd_data[15:8]};
            hlc_pkg::ACT_SEND: o_rsp_din <= {hlc_pkg::ADDR_SEND_COUNT, send_count};
            hlc_pkg::ACT_IDLE: o_rsp_din <= {hlc_pkg::ADDR_INACTIVE, hlc_pkg::INACTIVE_DATA};
            default: ;
        endcase
    end

    // Only a read may push into a nearly full response queue
    a_status_backoff: assert property (@(posedge clk) disable iff (rst)
        o_rsp_wr |-> !$past(i_rsp_almost_full) || $past(act == hlc_pkg::ACT_READ));

endmodule

/* hlc_return_mux.sv */
// Fixed-priority return multiplexer onto the 32-bit return stream
// CFG reply first, then loopback, then command response
// Output register reloads only when empty or transferring

`timescale 1ns/1ps

module hlc_return_mux (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         i_cfg_data,
    input  logic                i_cfg_valid,
    output logic                o_cfg_rd,
    input  hlc_pkg::loop_word_t i_loop_dout,
    input  logic                i_loop_valid,
    output logic                o_loop_rd,
    input  logic [31:0]         i_rsp_dout,
    input  logic                i_rsp_valid,
    output logic                o_rsp_rd,
    output hlc_pkg::ret_word_t  o_ret,
    output logic                o_ret_valid,
    input  logic                i_ret_ready
);

    logic               load;
    hlc_pkg::ret_src_e  sel;

    assign load = !o_ret_valid || i_ret_ready;      // Slot free this cycle

    always_comb begin
        sel = hlc_pkg::SRC_NONE;
        if (load) begin
            if (i_cfg_valid) begin
                sel = hlc_pkg::SRC_CFG;
            end else if (i_loop_valid) begin
                sel = hlc_pkg::SRC_LOOP;
            end else if (i_rsp_valid) begin
                sel = hlc_pkg::SRC_RSP;
            end
        end
    end

    // Pop exactly the source taken into the slot
    assign o_cfg_rd  = (sel == hlc_pkg::SRC_CFG);
    assign o_loop_rd = (sel == hlc_pkg::SRC_LOOP);
    assign o_rsp_rd  = (sel == hlc_pkg::SRC_RSP);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ret_valid <= 1'b0;
        end else if (load) begin
            o_ret_valid <= (sel != hlc_pkg::SRC_NONE);
        end
    end

    always_ff @(posedge clk) begin
        case (sel)
            hlc_pkg::SRC_CFG:  o_ret <= '{hlc_pkg::LT_CFG, 2'b00, i_cfg_data};
            hlc_pkg::SRC_LOOP: o_ret <= '{hlc_pkg::LT_LOOP, i_loop_dout.ctx, i_loop_dout.data};
            hlc_pkg::SRC_RSP:  o_ret <= '{hlc_pkg::LT_CMD, 2'b00, i_rsp_dout};
            default: ;                              // Hold while stalled
        endcase
    end

    a_one_pop: assert property (@(posedge clk) disable iff (rst)
        $onehot0({o_cfg_rd, o_loop_rd, o_rsp_rd}));

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        o_ret_valid && !i_ret_ready |=> o_ret_valid && $stable(o_ret));

endmodule

/* hlc_top.sv */
// Top level of the host-link packet controller
// Decode feeds the loopback and request FIFOs; the command engine feeds the response FIFO
// The return mux merges CFG replies, loopback and responses onto o_ret

`timescale 1ns/1ps

module hlc_top #(
    parameter logic [7:0] DEVICE_ID     = 8'h00,
    parameter logic [7:0] VERSION_MAJOR = 8'h00,
    parameter logic [7:0] VERSION_MINOR = 8'h00,
    parameter int         FIFO_DEPTH    = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  hlc_pkg::link_word_t i_link,
    input  logic                i_link_valid,
    output hlc_pkg::tlp_out_t   o_tlp,
    output hlc_pkg::cfg_out_t   o_cfg,
    input  logic [31:0]         i_cfg_data,
    input  logic                i_cfg_valid,
    output logic                o_cfg_rd,
    output hlc_pkg::ret_word_t  o_ret,
    output logic                o_ret_valid,
    input  logic                i_ret_ready
);

    hlc_pkg::loop_word_t loop_din, loop_dout;
    hlc_pkg::link_word_t req_din, req_dout;
    logic                loop_wr, loop_valid, loop_rd;
    logic                req_wr, req_valid, req_rd;
    logic                rsp_wr, rsp_valid, rsp_rd, rsp_afull;
    logic [31:0]         rsp_din, rsp_dout;

    hlc_link_decode u_decode (
        .i_link(i_link), .i_link_valid(i_link_valid), .o_tlp(o_tlp), .o_cfg(o_cfg),
        .o_loop_wr(loop_wr), .o_loop_din(loop_din), .o_cmd_wr(req_wr), .o_cmd_din(req_din)
    );

    // ------------------------------------------------
    // Queues
    // ------------------------------------------------
    hlc_sync_fifo #(.WIDTH($bits(hlc_pkg::loop_word_t)), .DEPTH(FIFO_DEPTH)) u_loop_fifo (
        .clk(clk), .rst(rst), .i_wr(loop_wr), .i_din(loop_din), .i_rd(loop_rd),
        .o_dout(loop_dout), .o_valid(loop_valid), .o_almost_full()
    );

    hlc_sync_fifo #(.WIDTH($bits(hlc_pkg::link_word_t)), .DEPTH(FIFO_DEPTH)) u_req_fifo (
        .clk(clk), .rst(rst), .i_wr(req_wr), .i_din(req_din), .i_rd(req_rd),
        .o_dout(req_dout), .o_valid(req_valid), .o_almost_full()
    );

    hlc_sync_fifo #(.WIDTH(32), .DEPTH(FIFO_DEPTH)) u_rsp_fifo (
        .clk(clk), .rst(rst), .i_wr(rsp_wr), .i_din(rsp_din), .i_rd(rsp_rd),
        .o_dout(rsp_dout), .o_valid(rsp_valid), .o_almost_full(rsp_afull)
    );

    hlc_cmd_engine #(
        .DEVICE_ID(DEVICE_ID), .VERSION_MAJOR(VERSION_MAJOR), .VERSION_MINOR(VERSION_MINOR)
    ) u_engine (
        .clk(clk), .rst(rst), .i_req(req_dout), .i_req_valid(req_valid), .o_req_rd(req_rd),
        .i_ret_xfer(o_ret_valid && i_ret_ready),    // Return stream handshake
        .i_ret_ready(i_ret_ready), .i_rsp_almost_full(rsp_afull),
        .o_rsp_wr(rsp_wr), .o_rsp_din(rsp_din)
    );

    hlc_return_mux u_mux (
        .clk(clk), .rst(rst),
        .i_cfg_data(i_cfg_data), .i_cfg_valid(i_cfg_valid), .o_cfg_rd(o_cfg_rd),
        .i_loop_dout(loop_dout), .i_loop_valid(loop_valid), .o_loop_rd(loop_rd),
        .i_rsp_dout(rsp_dout), .i_rsp_valid(rsp_valid), .o_rsp_rd(rsp_rd),
        .o_ret(o_ret), .o_ret_valid(o_ret_valid), .i_ret_ready(i_ret_ready)
    );

endmodule

/* tb_hlc.sv */
// Testbench for the host-link packet controller
// Drives link words, CFG replies and return-stream ready gaps into hlc_top
// Expected return words wait in one queue per source and are checked on transfer

`timescale 1ns/1ps

module tb_hlc;

    localparam logic [7:0] DEV_ID  = 8'h5a;
    localparam logic [7:0] VER_MAJ = 8'd4;
    localparam logic [7:0] VER_MIN = 8'd7;

    logic                clk = 1'b0;
    logic                rst;
    hlc_pkg::link_word_t i_link;
    logic                i_link_valid, i_cfg_valid, o_cfg_rd, o_ret_valid, i_ret_ready;
    logic [31:0]         i_cfg_data;
    hlc_pkg::tlp_out_t   o_tlp, exp_tlp;
    hlc_pkg::cfg_out_t   o_cfg, exp_cfg;
    hlc_pkg::ret_word_t  o_ret, chk_got, chk_exp;
    hlc_pkg::ret_word_t  cfg_exp_q[$], loop_exp_q[$], cmd_exp_q[$];
    logic [31:0]         cfg_src_q[$];           // Pending CFG replies, head on i_cfg_data
    logic [95:0]         rw_img;                 // Model of the RW register image
    logic [31:0]         rnd = 32'h44b4;
    logic                ready_random = 1'b0;
    logic                chk_xfer = 1'b0, chk_hit = 1'b0, route_ok = 1'b1;
    logic                sel_cfg = 1'b0, cfg_out = 1'b0, cfg_pop = 1'b0;

    hlc_top #(
        .DEVICE_ID(DEV_ID), .VERSION_MAJOR(VER_MAJ), .VERSION_MINOR(VER_MIN), .FIFO_DEPTH(16)
    ) i_dut (
        .clk(clk), .rst(rst), .i_link(i_link), .i_link_valid(i_link_valid),
        .o_tlp(o_tlp), .o_cfg(o_cfg), .i_cfg_data(i_cfg_data), .i_cfg_valid(i_cfg_valid),
        .o_cfg_rd(o_cfg_rd), .o_ret(o_ret), .o_ret_valid(o_ret_valid), .i_ret_ready(i_ret_ready)
    );

    always #4 clk = ~clk;                        // 8 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] swap16(input logic [15:0] v);
        return {v[7:0], v[15:8]};
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic hlc_pkg::link_word_t make_word(input hlc_pkg::link_type_e t,
            input logic [1:0] ctx, input logic [31:0] upper, input logic [15:0] addr,
            input logic rd, input logic wr);
        hlc_pkg::link_word_t w;
        w = '0;
        {w.value, w.mask} = upper;
        w.addr    = addr;
        w.rd_flag = rd;
        w.wr_flag = wr;
        w.ctx     = ctx;
        w.ltype   = t;
        w.magic   = hlc_pkg::LINK_MAGIC;
        return w;
    endfunction

    // Register map as 16 bits at a byte offset, zero past the end of a space
    function automatic logic [15:0] expected_read(input logic [15:0] addr);
        logic [271:0] ro_img;
        logic [111:0] rw_ext;
        int           bp;
        ro_img         = '0;
        ro_img[15:0]   = hlc_pkg::RO_MAGIC;
        ro_img[63:32]  = 32'(hlc_pkg::RO_BITS / 8);    // Bytecount
        ro_img[71:64]  = VER_MAJ;
        ro_img[79:72]  = VER_MIN;
        ro_img[87:80]  = DEV_ID;
        rw_ext = {16'h0000, rw_img};
        bp     = int'(addr[14:0]) * 8;
        if (addr[15]) begin
            return (bp < 96) ? rw_ext[bp +: 16] : 16'h0000;
        end
        return (bp < 256) ? ro_img[bp +: 16] : 16'h0000;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
        if (ready_random) begin
            rnd         = lcg_next(rnd);
            i_ret_ready = (rnd[17:16] != 2'b00);     // About one stall cycle in four
        end
    endtask

    // One link word for one cycle, expected strobes and returns queued with it
    task automatic send_link(input hlc_pkg::link_word_t w);
        logic        hit;
        logic [15:0] v;
        logic [15:0] m;
        int          bp;
        hit = (w.magic == hlc_pkg::LINK_MAGIC);
        v   = swap16(w.value);
        m   = swap16(w.mask);
        bp  = int'(w.addr[14:0]) * 8;
        exp_tlp.valid = hit && (w.ltype == hlc_pkg::LT_TLP);
        exp_tlp.last  = w.ctx[0];
        exp_tlp.data  = {w.value, w.mask};
        exp_cfg.valid = hit && (w.ltype == hlc_pkg::LT_CFG);
        exp_cfg.word  = w;
        if (hit && w.ltype == hlc_pkg::LT_LOOP) begin
            loop_exp_q.push_back({hlc_pkg::LT_LOOP, w.ctx, w.value, w.mask});
        end
        if (hit && w.ltype == hlc_pkg::LT_CMD && w.rd_flag) begin   // Read sees old data
            cmd_exp_q.push_back({hlc_pkg::LT_CMD, 2'b00, w.addr, swap16(expected_read(w.addr))});
        end
        if (hit && w.ltype == hlc_pkg::LT_CMD && w.wr_flag && w.addr[15]) begin
            for (int i = 0; i < 16; i++) begin
                if (m[i] && bp + i < 96) begin
                    rw_img[bp + i] = v[i];
                end
            end
        end
        i_link       = w;
        i_link_valid = 1'b1;
        tick();
        i_link_valid  = 1'b0;
        exp_tlp.valid = 1'b0;
        exp_cfg.valid = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr);
        send_link(make_word(hlc_pkg::LT_CMD, 2'b00, 32'h0, addr, 1'b1, 1'b0));
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] v, input logic [15:0] m);
        send_link(make_word(hlc_pkg::LT_CMD, 2'b00, {swap16(v), swap16(m)}, addr, 1'b0, 1'b1));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) tick();
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (cfg_exp_q.size() + loop_exp_q.size() + cmd_exp_q.size() != 0) begin
            if (n == limit) begin
                stop_on_error($sformatf("Timeout at %0t: expected return words never arrived",
                    $time));
            end else begin
                n++;
                tick();
            end
        end
        idle_cycles(4);                          // Let the last transfer get checked
    endtask

    // --------------------------------------------------
    // CFG reply source and return monitor
    // --------------------------------------------------
    always @(posedge clk) begin
        #2;                                      // After the main stimulus step
        if (cfg_pop) begin
            void'(cfg_src_q.pop_front());
        end
        i_cfg_valid = (cfg_src_q.size() != 0);
        i_cfg_data  = (cfg_src_q.size() != 0) ? cfg_src_q[0] : 32'h0;
    end

    // Mid-cycle sample, all values stable for the coming edge
    always @(negedge clk) begin
        chk_xfer = !rst && o_ret_valid && i_ret_ready;
        chk_hit  = 1'b0;
        chk_got  = o_ret;
        if (chk_xfer && o_ret.tag == hlc_pkg::LT_CFG && cfg_exp_q.size() != 0) begin
            chk_hit = 1'b1;
            chk_exp = cfg_exp_q.pop_front();
        end else if (chk_xfer && o_ret.tag == hlc_pkg::LT_LOOP && loop_exp_q.size() != 0) begin
            chk_hit = 1'b1;
            chk_exp = loop_exp_q.pop_front();
        end else if (chk_xfer && o_ret.tag == hlc_pkg::LT_CMD && cmd_exp_q.size() != 0) begin
            chk_hit = 1'b1;
            chk_exp = cmd_exp_q.pop_front();
        end
        sel_cfg  = !rst && (!o_ret_valid || i_ret_ready) && i_cfg_valid;   // Slot free, CFG waiting
        cfg_out  = o_ret_valid && (o_ret.tag == hlc_pkg::LT_CFG);
        cfg_pop  = o_cfg_rd;
        route_ok = (o_tlp.valid == exp_tlp.valid) && (!exp_tlp.valid || o_tlp == exp_tlp) &&
                   (o_cfg.valid == exp_cfg.valid) && (!exp_cfg.valid || o_cfg == exp_cfg);
    end

    a_ret_known: assert property (@(posedge clk) disable iff (rst) chk_xfer |-> chk_hit)
        else stop_on_error($sformatf("[FAIL] %0t: unexpected return word %h", $time, chk_got));

    a_ret_value: assert property (@(posedge clk) disable iff (rst)
        chk_xfer && chk_hit |-> chk_got == chk_exp)
        else stop_on_error($sformatf("[FAIL] %0t: return word %h, expected %h",
            $time, chk_got, chk_exp));

    a_cfg_first: assert property (@(posedge clk) disable iff (rst) sel_cfg |=> cfg_out)
        else stop_on_error($sformatf("[FAIL] %0t: CFG reply lost its priority", $time));

    a_routing: assert property (@(posedge clk) disable iff (rst) route_ok)
        else stop_on_error($sformatf("[FAIL] %0t: TLP/CFG strobe %h %h", $time, o_tlp, o_cfg));

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        hlc_pkg::link_word_t w;
        rst          = 1'b1;
        i_link       = '0;
        i_link_valid = 1'b0;
        i_cfg_valid  = 1'b0;
        i_cfg_data   = 32'h0;
        i_ret_ready  = 1'b1;
        exp_tlp      = '0;
        exp_cfg      = '0;
        rw_img = {32'h0, 32'(hlc_pkg::RW_BITS / 8), 16'h0000, hlc_pkg::RW_MAGIC};
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!o_ret_valid && !o_cfg_rd)
            else stop_on_error("Return stream was active right after reset");

        // Routing, then near misses on the magic for every type
        send_link(make_word(hlc_pkg::LT_TLP, 2'b01, 32'hdead_beef, 16'h1234, 1'b0, 1'b0));
        send_link(make_word(hlc_pkg::LT_TLP, 2'b10, 32'h0bad_f00d, 16'h0000, 1'b0, 1'b0));
        send_link(make_word(hlc_pkg::LT_CFG, 2'b11, 32'h0123_4567, 16'h0042, 1'b1, 1'b0));
        for (int t = 0; t < 4; t++) begin
            w       = make_word(hlc_pkg::link_type_e'(t), 2'b01, 32'hcafe_0000 + t, 16'h0,
                                1'b1, 1'b0);
            w.magic = 8'h76;
            send_link(w);
        end

        for (int k = 0; k < 8; k++) begin        // Loopback echo
            rnd = lcg_next(rnd);
            send_link(make_word(hlc_pkg::LT_LOOP, rnd[31:30], rnd, 16'h0, 1'b0, 1'b0));
        end
        wait_drain(200);

        read_reg(16'h0000);                      // RO magic
        read_reg(16'h0004);                      // Bytecount
        read_reg(16'h0008);                      // Version
        read_reg(16'h000a);                      // Device id
        read_reg(16'h8000);
        read_reg(16'h8004);
        write_reg(16'h8004, 16'h00a5, 16'h00f0); // Masked merge
        read_reg(16'h8004);
        write_reg(16'h0000, 16'h1111, 16'hffff); // RO space, ignored
        write_reg(16'h0008, 16'h2222, 16'hffff);
        read_reg(16'h0000);
        read_reg(16'h0008);
        read_reg(16'h8000);                      // RW words at the same offsets
        read_reg(16'h8008);
        read_reg(16'h0020);                      // Past the RO image
        read_reg(16'h800c);                      // Past the RW image
        wait_drain(200);

        // Send count runs N down to 1
        write_reg(16'h8004, 16'd5, 16'hffff);
        for (int c = 5; c >= 1; c--) begin
            cmd_exp_q.push_back({hlc_pkg::LT_CMD, 2'b00, hlc_pkg::ADDR_SEND_COUNT, 16'(c)});
        end
        write_reg(16'h8002, 16'h0002, 16'h0002);
        rw_img[47:32] = 16'h0000;
        wait_drain(200);
        idle_cycles(20);
        read_reg(16'h8004);
        wait_drain(100);

        // Inactivity fires once, then its enable is gone
        write_reg(16'h8008, 16'd20, 16'hffff);
        write_reg(16'h8002, 16'h0001, 16'h0001);
        cmd_exp_q.push_back({hlc_pkg::LT_CMD, 2'b00, hlc_pkg::ADDR_INACTIVE,
                             hlc_pkg::INACTIVE_DATA});
        rw_img[16] = 1'b0;
        wait_drain(300);
        idle_cycles(100);
        read_reg(16'h8002);
        wait_drain(100);

        // All three sources at once under random stalls
        ready_random = 1'b1;
        for (int k = 0; k < 8; k++) begin
            rnd = lcg_next(rnd);
            cfg_src_q.push_back(rnd);
            cfg_exp_q.push_back({hlc_pkg::LT_CFG, 2'b00, rnd});
        end
        for (int k = 0; k < 8; k++) begin
            rnd = lcg_next(rnd);
            send_link(make_word(hlc_pkg::LT_LOOP, rnd[31:30], rnd, 16'h0, 1'b0, 1'b0));
            if (k < 6) begin
                read_reg(16'(2 * k));
            end
        end
        wait_drain(600);
        ready_random = 1'b0;
        i_ret_ready  = 1'b1;
        idle_cycles(10);
        $display("all tests passed");
        $finish;
    end

endmodule

/* compile.f */
hlc_pkg.sv
hlc_sync_fifo.sv
hlc_link_decode.sv
hlc_cmd_engine.sv
hlc_return_mux.sv
hlc_top.sv
tb_hlc.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the host-link controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_hlc -o sim_hlc

# The log keeps the output of a failing run for the check below
./obj_dir/sim_hlc 2>&1 | tee sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
